//--- common/gpu_ctl_pkg.sv
`include "gpu_ctl_settings.svh"

package gpu_ctl_pkg;

    typedef enum logic [2:0] {
        TMC    = 3'd0,
        WSPAWN = 3'd1,
        SPLIT  = 3'd2,
        JOIN   = 3'd3,
        BAR    = 3'd4
    } gpu_op_e;

    // request from the issue stage
    typedef struct packed {
        logic [`NW_BITS-1:0]                wid;
        logic [`NUM_THREADS-1:0]            tmask;
        logic [31:0]                        pc;
        logic [31:0]                        next_pc;
        logic [4:0]                         rd;
        logic                               wb;
        gpu_op_e                            op;
        logic [`NUM_THREADS-1:0][31:0]      rs1_data;
        logic [31:0]                        rs2_data;
    } gpu_req_t;

    typedef struct packed {
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [31:0]             pc;
        logic [4:0]              rd;
        logic                    wb;
    } cmt_t;

    typedef struct packed {
        logic                    valid;
        logic [`NUM_THREADS-1:0] mask;
    } gpu_tmc_t;

    typedef struct packed {
        logic                  valid;
        logic [`NUM_WARPS-1:0] wmask;
        logic [31:0]           pc;
    } gpu_wspawn_t;

    typedef struct packed {
        logic                    valid;
        logic                    diverged;
        logic [`NUM_THREADS-1:0] then_mask;
        logic [`NUM_THREADS-1:0] else_mask;
        logic [`NUM_THREADS-1:0] orig_mask;
        logic [31:0]             pc;
    } gpu_split_t;

    typedef struct packed {
        logic valid;
    } gpu_join_t;

    typedef struct packed {
        logic                valid;
        logic [`NB_BITS-1:0] id;
        logic [`NW_BITS-1:0] size_m1;
    } gpu_barrier_t;

    // join is a keyword, hence join_op
    typedef struct packed {
        logic [`NW_BITS-1:0] wid;
        gpu_tmc_t            tmc;
        gpu_wspawn_t         wspawn;
        gpu_split_t          split;
        gpu_join_t           join_op;
        gpu_barrier_t        barrier;
    } warp_ctl_t;

    typedef struct packed {
        logic                    active;
        logic                    stalled;
        logic [`NUM_THREADS-1:0] tmask;
        logic [31:0]             pc;
    } warp_status_t;

    typedef struct packed {
        logic [`NUM_THREADS-1:0] mask;
        logic [31:0]             pc;
        logic                    fallthrough;
    } ipdom_entry_t;

endpackage

//--- common/gpu_ctl_settings.svh
`ifndef GPU_CTL_SETTINGS_SVH
`define GPU_CTL_SETTINGS_SVH

// threads per warp and warps per core
`define NUM_THREADS 4
`define NUM_WARPS   4

// barrier ids
`define NUM_BARRIERS 4
`define NB_BITS      2

// warp id width
`define NW_BITS 2

// reconvergence stack entries per warp
`define IPDOM_DEPTH 4

// reset pc of warp 0
`define START_PC 32'h0000_1000

`endif

//--- compile.f
+incdir+common
common/gpu_ctl_pkg.sv
rtl/gpu_unit.sv
warp_sched/ipdom_stack.sv
warp_sched/barrier_table.sv
warp_sched/warp_sched.sv
rtl/warp_ctl_top.sv
sim/warp_ctl_assert.sv
sim/tb_warp_ctl.sv

//--- rtl/gpu_unit.sv
`timescale 1ns/1ns
`include "gpu_ctl_settings.svh"

module gpu_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  gpu_ctl_pkg::gpu_req_t  req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output gpu_ctl_pkg::cmt_t      cmt,
    output logic                   cmt_valid,
    input  logic                   cmt_ready,
    output gpu_ctl_pkg::warp_ctl_t ctl,
    output logic                   ctl_valid
);
    import gpu_ctl_pkg::*;

    logic [`NUM_THREADS-1:0] tmc_mask;
    logic [`NUM_WARPS-1:0]   spawn_wmask;
    logic [`NUM_THREADS-1:0] taken;
    logic [`NUM_THREADS-1:0] then_mask;
    logic [`NUM_THREADS-1:0] else_mask;

    // count-style masks from thread 0's operand
    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            tmc_mask[i] = (32'(i) < req.rs1_data[0]);
        end
        for (int i = 0; i < `NUM_WARPS; i++) begin
            spawn_wmask[i] = (32'(i) < req.rs1_data[0]);
        end
    end

    // per-thread predicate for split
    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            taken[i]     = req.rs1_data[i][0];
            then_mask[i] = req.tmask[i] & taken[i];
            else_mask[i] = req.tmask[i] & ~taken[i];
        end
    end

    always_comb begin
        ctl.wid = req.wid;

        ctl.tmc.valid = (req.op == TMC);
        ctl.tmc.mask  = tmc_mask;

        ctl.wspawn.valid = (req.op == WSPAWN);
        ctl.wspawn.wmask = spawn_wmask;
        ctl.wspawn.pc    = req.rs2_data;

        ctl.split.valid     = (req.op == SPLIT);
        ctl.split.diverged  = (|then_mask) && (|else_mask);
        ctl.split.then_mask = then_mask;
        ctl.split.else_mask = else_mask;
        ctl.split.orig_mask = req.tmask;
        ctl.split.pc        = req.next_pc;

        ctl.join_op.valid = (req.op == JOIN);

        ctl.barrier.valid   = (req.op == BAR);
        ctl.barrier.id      = req.rs1_data[0][`NB_BITS-1:0];
        ctl.barrier.size_m1 = `NW_BITS'(req.rs2_data - 32'd1);
    end

    // accepted only when commit side can take it
    assign ctl_valid = req_valid && cmt_ready;

    assign cmt.wid   = req.wid;
    assign cmt.tmask = req.tmask;
    assign cmt.pc    = req.pc;
    assign cmt.rd    = req.rd;
    assign cmt.wb    = req.wb;

    assign cmt_valid = req_valid;
    assign req_ready = cmt_ready;

endmodule

//--- rtl/warp_ctl_top.sv
`timescale 1ns/1ns
`include "gpu_ctl_settings.svh"

module warp_ctl_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  gpu_ctl_pkg::gpu_req_t                      req,
    input  logic                                       req_valid,
    output logic                                       req_ready,
    output gpu_ctl_pkg::cmt_t                          cmt,
    output logic                                       cmt_valid,
    input  logic                                       cmt_ready,
    output gpu_ctl_pkg::warp_status_t [`NUM_WARPS-1:0] status
);
    import gpu_ctl_pkg::*;

    warp_ctl_t ctl;
    logic      ctl_valid;

    gpu_unit i_gpu_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .cmt       (cmt),
        .cmt_valid (cmt_valid),
        .cmt_ready (cmt_ready),
        .ctl       (ctl),
        .ctl_valid (ctl_valid)
    );

    warp_sched i_warp_sched (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .ctl_valid (ctl_valid),
        .status    (status)
    );

endmodule

//--- run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_warp_ctl \
    -o tb_warp_ctl || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_warp_ctl 2>&1)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "simulation ok" || { echo "simulation bad"; exit 1; }

//--- sim/tb_warp_ctl.sv
`timescale 1ns/1ns
`include "gpu_ctl_settings.svh"

module tb_warp_ctl;
    import gpu_ctl_pkg::*;

    localparam int NUM_ROWS       = 15;
    localparam int RESET_CYCLES   = 5;
    localparam int STALL_BITS     = 2;
    localparam int MAX_STALL      = (1 << STALL_BITS) - 1;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (MAX_STALL + 3) + RESET_CYCLES + 40;

    typedef struct packed {
        gpu_op_e                 op;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [31:0]             rs1;
        logic [`NUM_THREADS-1:0] pattern;
        logic [31:0]             rs2;
        logic [31:0]             next_pc;
        logic [`NW_BITS-1:0]     chk_wid;
        warp_status_t            exp;
    } row_t;

    logic                          clk;
    logic                          rst_n;
    gpu_req_t                      req;
    logic                          req_valid;
    logic                          req_ready;
    cmt_t                          cmt;
    logic                          cmt_valid;
    logic                          cmt_ready;
    warp_status_t [`NUM_WARPS-1:0] status;

    warp_status_t [`NUM_WARPS-1:0] reset_exp;
    cmt_t                          exp_cmt;
    logic [31:0]                   lfsr_state;
    int                            cycle_count = 0;

    string names [NUM_ROWS] = '{
        "tmc_count3", "wspawn_count4", "wspawn_keeps_w0", "tmc_count4", "split_diverged",
        "join_else_path", "join_reconverge", "split_uniform", "join_uniform", "tmc_zero_w3",
        "bar_w0_waits", "bar_w1_waits", "bar_w2_releases", "bar_w1_released",
        "bar_w2_not_stalled"
    };

    // op, wid, tmask, rs1 of thread 0, rs1 bit 0 per thread, rs2, next_pc, checked warp, expected
    row_t rows [NUM_ROWS] = '{
        '{TMC, 2'd0, 4'b0001, 32'd3, 4'b0000, 32'd0, 32'd0, 2'd0, '{1'b1, 1'b0, 4'b0111, `START_PC}},
        '{WSPAWN, 2'd0, 4'b0111, 32'd4, 4'b0000, 32'h2000, 32'd0, 2'd1,
          '{1'b1, 1'b0, 4'b0001, 32'h2000}},
        '{WSPAWN, 2'd0, 4'b0111, 32'd4, 4'b0000, 32'h3000, 32'd0, 2'd0,
          '{1'b1, 1'b0, 4'b0111, `START_PC}},
        '{TMC, 2'd0, 4'b0111, 32'd4, 4'b0000, 32'd0, 32'd0, 2'd0, '{1'b1, 1'b0, 4'b1111, `START_PC}},
        '{SPLIT, 2'd0, 4'b1111, 32'd1, 4'b0101, 32'd0, 32'h1100, 2'd0,
          '{1'b1, 1'b0, 4'b0101, `START_PC}},
        '{JOIN, 2'd0, 4'b0101, 32'd0, 4'b0000, 32'd0, 32'd0, 2'd0, '{1'b1, 1'b0, 4'b1010, 32'h1100}},
        '{JOIN, 2'd0, 4'b1010, 32'd0, 4'b0000, 32'd0, 32'd0, 2'd0, '{1'b1, 1'b0, 4'b1111, 32'h1100}},
        '{SPLIT, 2'd0, 4'b1111, 32'd1, 4'b1111, 32'd0, 32'h1200, 2'd0,
          '{1'b1, 1'b0, 4'b1111, 32'h1100}},
        '{JOIN, 2'd0, 4'b1111, 32'd0, 4'b0000, 32'd0, 32'd0, 2'd0, '{1'b1, 1'b0, 4'b1111, 32'h1100}},
        '{TMC, 2'd3, 4'b0001, 32'd0, 4'b0000, 32'd0, 32'd0, 2'd3, '{1'b0, 1'b0, 4'b0000, 32'h2000}},
        '{BAR, 2'd0, 4'b1111, 32'd1, 4'b0000, 32'd3, 32'd0, 2'd0, '{1'b1, 1'b1, 4'b1111, 32'h1100}},
        '{BAR, 2'd1, 4'b0001, 32'd1, 4'b0000, 32'd3, 32'd0, 2'd1, '{1'b1, 1'b1, 4'b0001, 32'h2000}},
        '{BAR, 2'd2, 4'b0001, 32'd1, 4'b0000, 32'd3, 32'd0, 2'd0, '{1'b1, 1'b0, 4'b1111, 32'h1100}},
        '{TMC, 2'd2, 4'b0001, 32'd1, 4'b0000, 32'd0, 32'd0, 2'd1, '{1'b1, 1'b0, 4'b0001, 32'h2000}},
        '{TMC, 2'd2, 4'b0001, 32'd1, 4'b0000, 32'd0, 32'd0, 2'd2, '{1'b1, 1'b0, 4'b0001, 32'h2000}}
    };

    warp_ctl_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .cmt       (cmt),
        .cmt_valid (cmt_valid),
        .cmt_ready (cmt_ready),
        .status    (status)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s: expected %h actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic compare_status(input string name,
                                  input warp_status_t [`NUM_WARPS-1:0] exp_all);
        for (int w = 0; w < `NUM_WARPS; w++) begin
            check_value($sformatf("%s_w%0d", name, w), 64'(exp_all[w]), 64'(status[w]));
        end
    endtask

    // galois form, taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_stall(output int n);
        n = 0;
        for (int b = 0; b < STALL_BITS; b++) begin
            n = n | (int'(lfsr_state[0]) << b);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic apply_row(input int i);
        row_t                          r;
        warp_status_t [`NUM_WARPS-1:0] snapshot;
        int                            n;
        r               = rows[i];
        req             = '0;
        req.wid         = r.wid;
        req.tmask       = r.tmask;
        req.pc          = r.next_pc - 32'd4;
        req.next_pc     = r.next_pc;
        req.op          = r.op;
        req.rs1_data[0] = r.rs1;
        for (int t = 1; t < `NUM_THREADS; t++) begin
            req.rs1_data[t] = {31'b0, r.pattern[t]};
        end
        req.rs2_data = r.rs2;
        req_valid    = 1'b1;
        draw_stall(n);
        cmt_ready = 1'b0;
        snapshot  = status;
        // back-pressure must freeze every warp
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            compare_status({names[i], "_held"}, snapshot);
        end
        cmt_ready = 1'b1;
        @(posedge clk);
        while (!(req_valid && req_ready)) begin
            @(posedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        check_value(names[i], 64'(r.exp), 64'(status[r.chk_wid]));
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        cmt_ready  = 1'b0;
        lfsr_state = 32'h42d8_2193;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_exp           = '0;
        reset_exp[0].active = 1'b1;
        reset_exp[0].tmask  = `NUM_THREADS'(1);
        reset_exp[0].pc     = `START_PC;
        compare_status("reset_state", reset_exp);

        // request parked while the commit side is busy
        req.wid         = 2'd1;
        req.tmask       = 4'b0011;
        req.pc          = 32'h0000_0a40;
        req.next_pc     = 32'h0000_0a44;
        req.rd          = 5'd7;
        req.wb          = 1'b1;
        req.op          = TMC;
        req.rs1_data[0] = 32'd3;
        req_valid       = 1'b1;
        exp_cmt         = '{2'd1, 4'b0011, 32'h0000_0a40, 5'd7, 1'b1};
        @(posedge clk);
        check_value("commit_fields", 64'(exp_cmt), 64'(cmt));
        check_value("commit_valid_high", 64'(1'b1), 64'(cmt_valid));
        check_value("req_ready_low", 64'(1'b0), 64'(req_ready));
        @(negedge clk);
        compare_status("held_no_change", reset_exp);
        req_valid = 1'b0;
        @(posedge clk);
        check_value("commit_valid_low", 64'(1'b0), 64'(cmt_valid));
        @(negedge clk);

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- sim/warp_ctl_assert.sv
`timescale 1ns/1ns
`include "gpu_ctl_settings.svh"

module warp_ctl_assert (
    input logic                                       clk,
    input logic                                       rst_n,
    input logic                                       req_valid,
    input logic                                       cmt_ready,
    input logic [`NUM_WARPS-1:0]                      stk_push,
    input logic [`NUM_WARPS-1:0]                      stk_pop,
    input logic [`NUM_WARPS-1:0]                      stk_empty,
    input logic [`NUM_WARPS-1:0]                      stk_full,
    input gpu_ctl_pkg::warp_status_t [`NUM_WARPS-1:0] status
);

    // nothing accepted means no warp state may move
    a_handshake: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_valid && cmt_ready) |=> $stable(status))
        else $error("warp status changed without an accepted request");

    for (genvar w = 0; w < `NUM_WARPS; w++) begin : g_warp
        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            !(stk_push[w] && stk_full[w]))
            else $error("warp %0d stack pushed while full", w);

        a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
            !(stk_pop[w] && stk_empty[w]))
            else $error("warp %0d stack popped while empty", w);

        // barrier wait only makes sense on a running warp
        a_stall_active: assert property (@(posedge clk) disable iff (!rst_n)
            !status[w].stalled || status[w].active)
            else $error("warp %0d stalled while inactive", w);
    end

endmodule

bind warp_ctl_top warp_ctl_assert i_warp_ctl_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .cmt_ready (cmt_ready),
    .stk_push  (i_warp_sched.stk_push),
    .stk_pop   (i_warp_sched.stk_pop),
    .stk_empty (i_warp_sched.stk_empty),
    .stk_full  (i_warp_sched.stk_full),
    .status    (status)
);

//--- warp_sched/barrier_table.sv
`timescale 1ns/1ns
`include "gpu_ctl_settings.svh"

module barrier_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  arrive,
    input  logic [`NB_BITS-1:0]   bar_id,
    input  logic [`NW_BITS-1:0]   size_m1,
    input  logic [`NW_BITS-1:0]   wid,
    output logic [`NUM_WARPS-1:0] release_mask,
    output logic                  last
);

    logic [`NW_BITS-1:0]   count   [`NUM_BARRIERS];
    logic [`NUM_WARPS-1:0] waiting [`NUM_BARRIERS];

    // arrival that brings the count to size_m1+1
    assign last         = arrive && (count[bar_id] == size_m1);
    assign release_mask = last ? waiting[bar_id] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                count[b]   <= '0;
                waiting[b] <= '0;
            end
        end else if (arrive) begin
            if (last) begin
                count[bar_id]   <= '0;
                waiting[bar_id] <= '0;
            end else begin
                count[bar_id]        <= count[bar_id] + 1'b1;
                waiting[bar_id][wid] <= 1'b1;
            end
        end
    end

endmodule

//--- warp_sched/ipdom_stack.sv
`timescale 1ns/1ns
`include "gpu_ctl_settings.svh"

module ipdom_stack (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  logic                      push2,
    input  logic                      pop,
    input  gpu_ctl_pkg::ipdom_entry_t push_data,
    input  gpu_ctl_pkg::ipdom_entry_t push2_data,
    output gpu_ctl_pkg::ipdom_entry_t top,
    output logic                      empty,
    output logic                      full
);
    import gpu_ctl_pkg::*;

    ipdom_entry_t entries [`IPDOM_DEPTH];

    // one extra bit so a full stack is distinguishable
    logic [$clog2(`IPDOM_DEPTH+1)-1:0] ptr;
    logic [$clog2(`IPDOM_DEPTH+1)-1:0] ptr_m1;
    logic [$clog2(`IPDOM_DEPTH)-1:0]   wr_idx;
    logic [$clog2(`IPDOM_DEPTH)-1:0]   wr_idx2;

    assign ptr_m1  = ptr - 1'b1;
    assign wr_idx  = ptr[$clog2(`IPDOM_DEPTH)-1:0];
    assign wr_idx2 = wr_idx + 1'b1;

    assign empty = (ptr == '0);
    assign full  = (ptr == `IPDOM_DEPTH);
    assign top   = entries[ptr_m1[$clog2(`IPDOM_DEPTH)-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (push && push2) begin
            ptr <= ptr + 2'd2;
        end else if (push) begin
            ptr <= ptr + 1'b1;
        end else if (pop && !empty) begin
            ptr <= ptr_m1;
        end
    end

    // second entry lands above the first
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_idx] <= push_data;
        end
        if (push && push2) begin
            entries[wr_idx2] <= push2_data;
        end
    end

endmodule

//--- warp_sched/warp_sched.sv
`timescale 1ns/1ns
`include "gpu_ctl_settings.svh"

module warp_sched (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  gpu_ctl_pkg::warp_ctl_t                        ctl,
    input  logic                                          ctl_valid,
    output gpu_ctl_pkg::warp_status_t [`NUM_WARPS-1:0]    status
);
    import gpu_ctl_pkg::*;

    logic do_tmc;
    logic do_wspawn;
    logic do_split;
    logic do_join;
    logic do_bar;

    logic [`NUM_WARPS-1:0] stk_push;
    logic [`NUM_WARPS-1:0] stk_push2;
    logic [`NUM_WARPS-1:0] stk_pop;
    logic [`NUM_WARPS-1:0] stk_empty;
    logic [`NUM_WARPS-1:0] stk_full;

    ipdom_entry_t                  push_data;
    ipdom_entry_t                  push2_data;
    ipdom_entry_t [`NUM_WARPS-1:0] stk_top;

    logic [`NUM_WARPS-1:0] release_mask;
    logic                  bar_last;

    assign do_tmc    = ctl_valid && ctl.tmc.valid;
    assign do_wspawn = ctl_valid && ctl.wspawn.valid;
    assign do_split  = ctl_valid && ctl.split.valid;
    assign do_join   = ctl_valid && ctl.join_op.valid;
    assign do_bar    = ctl_valid && ctl.barrier.valid;

    // reconvergence entry below, else path on top
    assign push_data.mask         = ctl.split.orig_mask;
    assign push_data.pc           = ctl.split.pc;
    assign push_data.fallthrough  = 1'b0;
    assign push2_data.mask        = ctl.split.else_mask;
    assign push2_data.pc          = ctl.split.pc;
    assign push2_data.fallthrough = 1'b1;

    for (genvar w = 0; w < `NUM_WARPS; w++) begin : g_stack
        assign stk_push[w]  = do_split && (ctl.wid == `NW_BITS'(w));
        assign stk_push2[w] = stk_push[w] && ctl.split.diverged;
        assign stk_pop[w]   = do_join && (ctl.wid == `NW_BITS'(w));

        ipdom_stack i_ipdom_stack (
            .clk        (clk),
            .rst_n      (rst_n),
            .push       (stk_push[w]),
            .push2      (stk_push2[w]),
            .pop        (stk_pop[w]),
            .push_data  (push_data),
            .push2_data (push2_data),
            .top        (stk_top[w]),
            .empty      (stk_empty[w]),
            .full       (stk_full[w])
        );
    end

    barrier_table i_barrier_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .arrive       (do_bar),
        .bar_id       (ctl.barrier.id),
        .size_m1      (ctl.barrier.size_m1),
        .wid          (ctl.wid),
        .release_mask (release_mask),
        .last         (bar_last)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
            status[0].active <= 1'b1;
            status[0].tmask  <= `NUM_THREADS'(1);
            status[0].pc     <= `START_PC;
        end else begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                if (release_mask[w]) begin
                    status[w].stalled <= 1'b0;
                end
            end

            if (do_tmc) begin
                status[ctl.wid].tmask  <= ctl.tmc.mask;
                status[ctl.wid].active <= |ctl.tmc.mask;
            end

            // only idle warps are started, requester left alone
            if (do_wspawn) begin
                for (int w = 0; w < `NUM_WARPS; w++) begin
                    if (ctl.wspawn.wmask[w] && (w != int'(ctl.wid)) && !status[w].active) begin
                        status[w].active <= 1'b1;
                        status[w].tmask  <= `NUM_THREADS'(1);
                        status[w].pc     <= ctl.wspawn.pc;
                    end
                end
            end

            if (do_split && ctl.split.diverged) begin
                status[ctl.wid].tmask <= ctl.split.then_mask;
            end

            if (do_join && !stk_empty[ctl.wid]) begin
                status[ctl.wid].tmask <= stk_top[ctl.wid].mask;
                if (stk_top[ctl.wid].fallthrough) begin
                    status[ctl.wid].pc <= stk_top[ctl.wid].pc;
                end
            end

            // last arrival never waits
            if (do_bar && !bar_last) begin
                status[ctl.wid].stalled <= 1'b1;
            end
        end
    end

endmodule
